// ==== rtl/fb_buffer_pkg.sv ====
package fb_buffer_pkg;

    localparam int NUM_FRAMES  = 3;
    localparam int NUM_CLIENTS = 2;

    // role index doubles as the client slot in every port array
    localparam int CLIENT_PRODUCER = 0;
    localparam int CLIENT_CONSUMER = 1;

    typedef logic [1:0] buf_idx_t;

    typedef enum logic [1:0] {
        AVAILABLE,
        WRITE_BUSY,
        UPDATED,
        DISPLAYED
    } buf_state_e;

    typedef enum logic [3:0] {
        IDLE,
        START_WAIT,
        LOCK,
        FIND,
        SELECT,
        START,
        DONE_WAIT,
        RELEASE_WAIT,
        RELEASE
    } seq_state_e;

endpackage

// ==== rtl/fb_mem_pkg.sv ====
package fb_mem_pkg;

    // word addressed frame memory
    localparam int ADDR_W = 21;

    typedef logic [ADDR_W-1:0] addr_t;

    // spare words between consecutive frames
    localparam int FRAME_GUARD = 32;

    // warm-up counter after memory init
    typedef logic [7:0] delay_cnt_t;

endpackage

// ==== rtl/buffer_port_if.sv ====
`timescale 1ns/1ns

interface buffer_port_if
    import fb_mem_pkg::*;
();

    logic  lock_req;
    logic  lock_gnt;
    logic  find;
    logic  select;
    logic  release_buf;
    addr_t base_addr;

    modport seq (
        output lock_req, find, select, release_buf,
        input  lock_gnt, base_addr
    );

    modport arb (input lock_req, output lock_gnt);

    modport tbl (input find, select, release_buf, output base_addr);

endinterface

// ==== rtl/mem_ready_timer.sv ====
`timescale 1ns/1ns

module mem_ready_timer
    import fb_mem_pkg::*;
#(
    parameter int INIT_DELAY = 152
) (
    input  logic clk,
    input  logic rst_n,
    input  logic init_done_i,
    output logic ready_o
);

    localparam delay_cnt_t DELAY_END = delay_cnt_t'(INIT_DELAY);

    delay_cnt_t cnt_q;
    logic       ready_q;

    // saturates at the delay, ready follows one cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q   <= '0;
            ready_q <= 1'b0;
        end else begin
            if (init_done_i && cnt_q != DELAY_END)
                cnt_q <= cnt_q + 1'b1;
            if (cnt_q == DELAY_END)
                ready_q <= 1'b1;
        end
    end

    assign ready_o = ready_q;

endmodule

// ==== rtl/lock_arbiter.sv ====
`timescale 1ns/1ns

module lock_arbiter
    import fb_buffer_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    buffer_port_if.arb     port_arb [NUM_CLIENTS]
);

    localparam int IDX_W = (NUM_CLIENTS > 1) ? $clog2(NUM_CLIENTS) : 1;

    logic [NUM_CLIENTS-1:0] req;
    logic                   busy_q;
    logic [IDX_W-1:0]       owner_q;
    logic [IDX_W-1:0]       pick;
    logic [IDX_W-1:0]       cand;
    logic                   found;

    // owner_q keeps the last winner once the lock is free
    always_comb begin
        pick  = owner_q;
        cand  = owner_q;
        found = 1'b0;
        for (int i = 1; i <= NUM_CLIENTS; i++) begin
            cand = IDX_W'((int'(owner_q) + i) % NUM_CLIENTS);
            if (!found && req[cand]) begin
                pick  = cand;
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q  <= 1'b0;
            owner_q <= IDX_W'(NUM_CLIENTS - 1);
        end else if (busy_q) begin
            if (!req[owner_q])
                busy_q <= 1'b0;
        end else if (found) begin
            busy_q  <= 1'b1;
            owner_q <= pick;
        end
    end

    for (genvar g = 0; g < NUM_CLIENTS; g++) begin : g_client
        assign req[g]               = port_arb[g].lock_req;
        assign port_arb[g].lock_gnt = busy_q && (owner_q == IDX_W'(g));
    end

endmodule

// ==== rtl/frame_sequencer.sv ====
`timescale 1ns/1ns

module frame_sequencer
    import fb_buffer_pkg::*;
    import fb_mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ready_i,
    input  logic        done_i,
    output logic        start_o,
    output addr_t       base_addr_o,
    buffer_port_if.seq  port_seq
);

    seq_state_e state_q;
    seq_state_e state_d;
    logic       start_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:
                state_d = START_WAIT;
            START_WAIT:
                if (ready_i)
                    state_d = LOCK;
            LOCK:
                if (port_seq.lock_gnt)
                    state_d = FIND;
            FIND:
                state_d = SELECT;
            SELECT:
                state_d = START;
            START:
                state_d = DONE_WAIT;
            // done outside this state is dropped
            DONE_WAIT:
                if (done_i)
                    state_d = RELEASE_WAIT;
            RELEASE_WAIT:
                if (port_seq.lock_gnt)
                    state_d = RELEASE;
            RELEASE:
                state_d = IDLE;
            default:
                state_d = IDLE;
        endcase
    end

    // table stays locked from find to select and over the release
    assign port_seq.lock_req = (state_q == LOCK) || (state_q == FIND) ||
                               (state_q == SELECT) || (state_q == RELEASE_WAIT) ||
                               (state_q == RELEASE);

    assign port_seq.find        = (state_q == FIND);
    assign port_seq.select      = (state_q == SELECT);
    assign port_seq.release_buf = (state_q == RELEASE);

    // high during START, base address already latched by then
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            start_q <= 1'b0;
        else
            start_q <= (state_q == SELECT);
    end

    assign start_o     = start_q;
    assign base_addr_o = port_seq.base_addr;

endmodule

// ==== rtl/buffer_table.sv ====
`timescale 1ns/1ns

module buffer_table
    import fb_buffer_pkg::*;
    import fb_mem_pkg::*;
#(
    parameter int FRAME_WIDTH  = 640,
    parameter int FRAME_HEIGHT = 480
) (
    input  logic        clk,
    input  logic        rst_n,
    buffer_port_if.tbl  port_tbl [NUM_CLIENTS]
);

    localparam int STRIDE    = FRAME_WIDTH * FRAME_HEIGHT + FRAME_GUARD;
    localparam int NUM_RANKS = 3;

    buf_state_e             slot_q [NUM_FRAMES];
    buf_idx_t               idx_q  [NUM_CLIENTS];
    addr_t                  base_q [NUM_CLIENTS];
    buf_idx_t               pick   [NUM_CLIENTS];
    logic [NUM_CLIENTS-1:0] hit;
    logic [NUM_CLIENTS-1:0] find_v;
    logic [NUM_CLIENTS-1:0] select_v;
    logic [NUM_CLIENTS-1:0] release_v;

    // state class searched at each rank, per role
    function automatic buf_state_e prio_state(input int client, input int rank);
        case (rank)
            0:       return (client == CLIENT_PRODUCER) ? DISPLAYED : UPDATED;
            1:       return AVAILABLE;
            default: return (client == CLIENT_PRODUCER) ? UPDATED : DISPLAYED;
        endcase
    endfunction

    function automatic addr_t slot_base(input buf_idx_t idx);
        return addr_t'(int'(idx) * STRIDE);
    endfunction

    // lowest index wins within a class, busy slots never match
    always_comb begin
        for (int c = 0; c < NUM_CLIENTS; c++) begin
            pick[c] = idx_q[c];
            hit[c]  = 1'b0;
            for (int r = 0; r < NUM_RANKS; r++) begin
                for (int s = 0; s < NUM_FRAMES; s++) begin
                    if (!hit[c] && slot_q[s] == prio_state(c, r)) begin
                        pick[c] = buf_idx_t'(s);
                        hit[c]  = 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_FRAMES; s++)
                slot_q[s] <= AVAILABLE;
            for (int c = 0; c < NUM_CLIENTS; c++) begin
                idx_q[c]  <= '0;
                base_q[c] <= '0;
            end
        end else begin
            for (int c = 0; c < NUM_CLIENTS; c++) begin
                if (find_v[c])
                    idx_q[c] <= pick[c];
                if (select_v[c]) begin
                    slot_q[idx_q[c]] <= WRITE_BUSY;
                    base_q[c]        <= slot_base(idx_q[c]);
                end
                if (release_v[c])
                    slot_q[idx_q[c]] <= (c == CLIENT_PRODUCER) ? UPDATED : DISPLAYED;
            end
        end
    end

    for (genvar g = 0; g < NUM_CLIENTS; g++) begin : g_client
        assign find_v[g]              = port_tbl[g].find;
        assign select_v[g]            = port_tbl[g].select;
        assign release_v[g]           = port_tbl[g].release_buf;
        assign port_tbl[g].base_addr = base_q[g];
    end

endmodule

// ==== rtl/frame_buffer_ctrl.sv ====
`timescale 1ns/1ns

module frame_buffer_ctrl
    import fb_buffer_pkg::*;
    import fb_mem_pkg::*;
#(
    parameter int FRAME_WIDTH  = 640,
    parameter int FRAME_HEIGHT = 480,
    parameter int INIT_DELAY   = 152
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  init_done_i,
    input  logic  wr_done_i,
    input  logic  rd_done_i,
    output logic  wr_start_o,
    output addr_t wr_base_addr_o,
    output logic  rd_start_o,
    output addr_t rd_base_addr_o
);

    logic                   ready;
    logic [NUM_CLIENTS-1:0] done_v;
    logic [NUM_CLIENTS-1:0] start_v;
    addr_t                  base_v [NUM_CLIENTS];

    buffer_port_if port_if [NUM_CLIENTS] ();

    // producer is the camera upload, consumer the display download
    assign done_v[CLIENT_PRODUCER] = wr_done_i;
    assign done_v[CLIENT_CONSUMER] = rd_done_i;

    assign wr_start_o     = start_v[CLIENT_PRODUCER];
    assign wr_base_addr_o = base_v[CLIENT_PRODUCER];
    assign rd_start_o     = start_v[CLIENT_CONSUMER];
    assign rd_base_addr_o = base_v[CLIENT_CONSUMER];

    mem_ready_timer #(
        .INIT_DELAY (INIT_DELAY)
    ) u_ready_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .init_done_i (init_done_i),
        .ready_o     (ready)
    );

    lock_arbiter u_lock_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .port_arb (port_if)
    );

    buffer_table #(
        .FRAME_WIDTH  (FRAME_WIDTH),
        .FRAME_HEIGHT (FRAME_HEIGHT)
    ) u_buffer_table (
        .clk      (clk),
        .rst_n    (rst_n),
        .port_tbl (port_if)
    );

    for (genvar g = 0; g < NUM_CLIENTS; g++) begin : g_seq
        frame_sequencer u_sequencer (
            .clk         (clk),
            .rst_n       (rst_n),
            .ready_i     (ready),
            .done_i      (done_v[g]),
            .start_o     (start_v[g]),
            .base_addr_o (base_v[g]),
            .port_seq    (port_if[g])
        );
    end

endmodule

// ==== tests/frame_buffer_ctrl_asserts.sv ====
`timescale 1ns/1ns

module frame_buffer_ctrl_asserts
    import fb_buffer_pkg::*;
    import fb_mem_pkg::*;
#(
    parameter int FRAME_WIDTH  = 640,
    parameter int FRAME_HEIGHT = 480,
    parameter int INIT_DELAY   = 152
) (
    input logic  clk,
    input logic  rst_n,
    input logic  init_done_i,
    input logic  wr_done_i,
    input logic  rd_done_i,
    input logic  wr_start_i,
    input logic  rd_start_i,
    input addr_t wr_base_i,
    input addr_t rd_base_i
);

    localparam int STRIDE = FRAME_WIDTH * FRAME_HEIGHT + FRAME_GUARD;

    int unsigned            errors = 0;
    int                     init_cnt;
    buf_state_e             slot_q [NUM_FRAMES];
    buf_state_e             nxt    [NUM_FRAMES];
    buf_state_e             view   [NUM_FRAMES];
    int                     own_q  [NUM_CLIENTS];
    int                     exp0   [NUM_CLIENTS];
    int                     exp1   [NUM_CLIENTS];
    int                     got    [NUM_CLIENTS];
    addr_t                  base_v [NUM_CLIENTS];
    logic [NUM_CLIENTS-1:0] start_v;
    logic [NUM_CLIENTS-1:0] done_v;
    logic [NUM_CLIENTS-1:0] pend_q;
    logic [NUM_CLIENTS-1:0] rel_q;
    logic [NUM_CLIENTS-1:0] pick_ok;

    assign start_v   = {rd_start_i, wr_start_i};
    assign done_v    = {rd_done_i, wr_done_i};
    assign base_v[0] = wr_base_i;
    assign base_v[1] = rd_base_i;

    // lower rank is preferred, busy slots rank last
    function automatic int rank_of(input buf_state_e st, input int c);
        case (st)
            AVAILABLE: return 1;
            UPDATED:   return (c == CLIENT_PRODUCER) ? 2 : 0;
            DISPLAYED: return (c == CLIENT_PRODUCER) ? 0 : 2;
            default:   return 3;
        endcase
    endfunction

    function automatic int best_slot(input buf_state_e v [NUM_FRAMES], input int c);
        int best;
        best = 0;
        for (int s = 1; s < NUM_FRAMES; s++)
            if (rank_of(v[s], c) < rank_of(v[best], c))
                best = s;
        return best;
    endfunction

    function automatic buf_state_e freed_state(input int c);
        return (c == CLIENT_PRODUCER) ? UPDATED : DISPLAYED;
    endfunction

    // a done but not yet restarted side may or may not have released its slot
    always_comb begin
        nxt = slot_q;
        for (int c = 0; c < NUM_CLIENTS; c++) begin
            view = slot_q;
            if (rel_q[c])
                view[own_q[c]] = freed_state(c);
            exp0[c] = best_slot(view, c);
            if (rel_q[1 - c])
                view[own_q[1 - c]] = freed_state(1 - c);
            exp1[c] = best_slot(view, c);
            got[c] = int'(base_v[c]) / STRIDE;
            pick_ok[c] = (int'(base_v[c]) == exp0[c] * STRIDE) ||
                         (int'(base_v[c]) == exp1[c] * STRIDE);
            if (start_v[c]) begin
                if (rel_q[c])
                    nxt[own_q[c]] = freed_state(c);
                if (got[c] < NUM_FRAMES)
                    nxt[got[c]] = WRITE_BUSY;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            init_cnt <= 0;
            pend_q   <= '0;
            rel_q    <= '0;
            for (int s = 0; s < NUM_FRAMES; s++)
                slot_q[s] <= AVAILABLE;
            for (int c = 0; c < NUM_CLIENTS; c++)
                own_q[c] <= 0;
        end else begin
            if (init_done_i && init_cnt < INIT_DELAY)
                init_cnt <= init_cnt + 1;
            slot_q <= nxt;
            for (int c = 0; c < NUM_CLIENTS; c++) begin
                if (start_v[c]) begin
                    pend_q[c] <= 1'b1;
                    rel_q[c]  <= 1'b0;
                    own_q[c]  <= got[c];
                    // slot of the other side taken over, so that release is settled
                    if (rel_q[1 - c] && own_q[1 - c] == got[c])
                        rel_q[1 - c] <= 1'b0;
                end else if (done_v[c] && pend_q[c]) begin
                    pend_q[c] <= 1'b0;
                    rel_q[c]  <= 1'b1;
                end
            end
        end
    end

    a_init_delay: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_start_i || rd_start_i) |-> init_cnt >= INIT_DELAY)
    else begin
        $error("start pulse before the memory init delay elapsed");
        errors++;
    end

    a_disjoint: assert property (@(posedge clk) disable iff (!rst_n)
        (pend_q[0] || wr_start_i) && (pend_q[1] || rd_start_i) |-> wr_base_i != rd_base_i)
    else begin
        $error("producer and consumer share the buffer at %0h", $sampled(wr_base_i));
        errors++;
    end

    for (genvar g = 0; g < NUM_CLIENTS; g++) begin : g_side
        a_single_start: assert property (@(posedge clk) disable iff (!rst_n)
            start_v[g] |-> !pend_q[g] ##1 !start_v[g])
        else begin
            $error("side %0d start repeated before its done or longer than a cycle", g);
            errors++;
        end

        a_slot_pick: assert property (@(posedge clk) disable iff (!rst_n)
            start_v[g] |-> pick_ok[g])
        else begin
            $error("MISMATCH slot_pick_%0d expected %0h or %0h actual %0h", g,
                   $sampled(exp0[g]) * STRIDE, $sampled(exp1[g]) * STRIDE,
                   $sampled(base_v[g]));
            errors++;
        end
    end

endmodule

bind frame_buffer_ctrl frame_buffer_ctrl_asserts #(
    .FRAME_WIDTH  (FRAME_WIDTH),
    .FRAME_HEIGHT (FRAME_HEIGHT),
    .INIT_DELAY   (INIT_DELAY)
) u_asserts (
    .clk         (clk),
    .rst_n       (rst_n),
    .init_done_i (init_done_i),
    .wr_done_i   (wr_done_i),
    .rd_done_i   (rd_done_i),
    .wr_start_i  (wr_start_o),
    .rd_start_i  (rd_start_o),
    .wr_base_i   (wr_base_addr_o),
    .rd_base_i   (rd_base_addr_o)
);

// ==== tests/tb_frame_buffer_ctrl.sv ====
`timescale 1ns/1ns

module tb_frame_buffer_ctrl
    import fb_mem_pkg::*;
();

    localparam int INIT_CYCLES  = 20;
    localparam int WARM_FRAMES  = 10;
    localparam int STALL_FRAMES = 6;
    // lock waits on both sides, longest mover delay and the release
    localparam int PASS_CYCLES  = 40;
    localparam int LIMIT_CYCLES = 16 + INIT_CYCLES +
                                  (2 * WARM_FRAMES + STALL_FRAMES + 4) * PASS_CYCLES;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        init_done_i;
    logic        wr_done_i;
    logic        rd_done_i;
    logic        wr_start_o;
    logic        rd_start_o;
    addr_t       wr_base_addr_o;
    addr_t       rd_base_addr_o;
    logic [31:0] lcg_state;
    logic        rd_hold;
    int          wr_wait;
    int          rd_wait;
    int          wr_frames;
    int          target;

    frame_buffer_ctrl #(
        .FRAME_WIDTH  (8),
        .FRAME_HEIGHT (4),
        .INIT_DELAY   (INIT_CYCLES)
    ) UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .init_done_i    (init_done_i),
        .wr_done_i      (wr_done_i),
        .rd_done_i      (rd_done_i),
        .wr_start_o     (wr_start_o),
        .wr_base_addr_o (wr_base_addr_o),
        .rd_start_o     (rd_start_o),
        .rd_base_addr_o (rd_base_addr_o)
    );

    always #20 clk = ~clk;

    // 1 to 15 cycles from the upper bits of the generator
    function automatic int next_delay();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return 1 + int'(lcg_state[27:24]) % 15;
    endfunction

    // answers each start with a done strobe after a random delay
    // read side stays one cycle short of done while held
    always @(negedge clk) begin
        wr_done_i = 1'b0;
        rd_done_i = 1'b0;
        if (wr_start_o) begin
            wr_wait = next_delay();
        end else if (wr_wait > 0) begin
            wr_wait = wr_wait - 1;
            wr_done_i = (wr_wait == 0);
            if (wr_wait == 0)
                wr_frames = wr_frames + 1;
        end
        if (rd_start_o) begin
            rd_wait = next_delay();
        end else if (rd_wait > 1 || (rd_wait == 1 && !rd_hold)) begin
            rd_wait = rd_wait - 1;
            rd_done_i = (rd_wait == 0);
        end
    end

    always @(UUT.u_asserts.errors) begin
        if (UUT.u_asserts.errors != 0) begin
            $display("tests failed");
            $fatal(1, "an assertion failed, see the error above");
        end
    end

    initial begin
        #(LIMIT_CYCLES * 40);
        $display("tests failed");
        $fatal(1, "watchdog expired before the frame sequence completed");
    end

    initial begin
        rst_n       = 1'b0;
        init_done_i = 1'b0;
        wr_done_i   = 1'b0;
        rd_done_i   = 1'b0;
        rd_hold     = 1'b0;
        lcg_state   = 32'h1545;
        wr_wait     = 0;
        rd_wait     = 0;
        wr_frames   = 0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        init_done_i = 1'b1;
        wait (wr_frames >= WARM_FRAMES);
        // display keeps its buffer while the camera runs on
        rd_hold = 1'b1;
        wait (rd_wait == 1);
        target = wr_frames + STALL_FRAMES;
        wait (wr_frames >= target);
        rd_hold = 1'b0;
        target = wr_frames + WARM_FRAMES;
        wait (wr_frames >= target);
        repeat (4) @(negedge clk);
        if (UUT.u_asserts.errors == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("tests failed");
            $fatal(1, "assertion failures were reported");
        end
    end

endmodule

// ==== compile.f ====
rtl/fb_buffer_pkg.sv
rtl/fb_mem_pkg.sv
rtl/buffer_port_if.sv
rtl/mem_ready_timer.sv
rtl/lock_arbiter.sv
rtl/frame_sequencer.sv
rtl/buffer_table.sv
rtl/frame_buffer_ctrl.sv
tests/frame_buffer_ctrl_asserts.sv
tests/tb_frame_buffer_ctrl.sv
